// ==== socket_mem.f ====
logic/socket_pkg.sv
logic/socket_dcr_regs.sv
logic/socket_req_arb.sv
logic/socket_req_buf.sv
logic/socket_rsp_route.sv
logic/socket_top.sv
tests/socket_tb_mem.sv
tests/socket_tb.sv

// ==== tests/socket_tb.sv ====
// Testbench for the socket memory concentrator.
// Four cores issue random reads and writes through socket_top into a memory
// model. Requests, responses and the APB registers are checked as they pass.

`timescale 1ns/1ps
`default_nettype none

module socket_tb;
    import socket_pkg::*;

    localparam int NUM_CORES = 4;
    localparam int IDX_W     = 2;
    localparam int MEM_TAG_W = CORE_TAG_W + IDX_W;
    localparam int N_RR      = 8;
    localparam int N_STALL   = 12;
    localparam int N_MASK    = 6;
    localparam int MAX_REQ   = N_RR + N_STALL + N_MASK;
    localparam int TOTAL_REQ = NUM_CORES * MAX_REQ;
    localparam int SEED      = 81344;

    logic                             clk;
    logic                             rst_n;
    logic                             stall_en;
    logic      [NUM_CORES-1:0]        core_req_valid;
    logic      [NUM_CORES-1:0]        core_req_ready;
    logic      [NUM_CORES-1:0]        core_req_write;
    addr_t     [NUM_CORES-1:0]        core_req_addr;
    data_t     [NUM_CORES-1:0]        core_req_data;
    core_tag_t [NUM_CORES-1:0]        core_req_tag;
    logic      [NUM_CORES-1:0]        core_rsp_valid;
    logic      [NUM_CORES-1:0]        core_rsp_ready;
    data_t     [NUM_CORES-1:0]        core_rsp_data;
    core_tag_t [NUM_CORES-1:0]        core_rsp_tag;
    logic                             mem_req_valid;
    logic                             mem_req_ready;
    logic                             mem_req_write;
    addr_t                            mem_req_addr;
    data_t                            mem_req_data;
    logic      [MEM_TAG_W-1:0]        mem_req_tag;
    logic                             mem_rsp_valid;
    logic                             mem_rsp_ready;
    data_t                            mem_rsp_data;
    logic      [MEM_TAG_W-1:0]        mem_rsp_tag;
    addr_t                            paddr;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    data_t                            pwdata;
    data_t                            prdata;
    logic                             pready;
    logic                             pslverr;
    logic                             busy;

    // per-core request lists and progress counters
    addr_t                 req_addr  [NUM_CORES][MAX_REQ];
    data_t                 req_data  [NUM_CORES][MAX_REQ];
    core_tag_t             req_tag   [NUM_CORES][MAX_REQ];
    logic                  req_write [NUM_CORES][MAX_REQ];
    int                    limit     [NUM_CORES];
    int                    issued    [NUM_CORES];
    int                    mem_cnt   [NUM_CORES];
    int                    rsp_cnt   [NUM_CORES];
    logic [NUM_CORES-1:0]  en_expect;
    logic [IDX_W-1:0]      last_idx;
    logic                  rr_mode;
    int                    mem_total;
    integer                seed;

    socket_top #(.NUM_CORES(NUM_CORES)) socket_top_i (.*);

    socket_tb_mem #(.MEM_TAG_W(MEM_TAG_W), .SEED(SEED)) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // reference model and compares

    function automatic data_t expected_data(input addr_t addr);
        return {addr[23:0], addr[31:24]} ^ 32'h5A5A5A5A;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(input addr_t exp, input addr_t act, input string name);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_data(input data_t exp, input data_t act, input string name);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_tag(input core_tag_t exp, input core_tag_t act, input string name);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input logic [31:0] exp, input logic [31:0] act, input string name);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic exp, input logic act, input string name);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_index(input logic [IDX_W-1:0] exp, input logic [IDX_W-1:0] act,
                               input string name);
        if (exp !== act) begin
            $display("error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    //////////////////////////////
    // stimulus

    always @(negedge clk) begin : drive_cores
        int k;
        for (int i = 0; i < NUM_CORES; i++) begin
            k = (issued[i] < limit[i]) ? issued[i] : 0;
            core_req_valid[i] = (issued[i] < limit[i]);
            core_req_write[i] = req_write[i][k];
            core_req_addr[i]  = req_addr[i][k];
            core_req_data[i]  = req_data[i][k];
            core_req_tag[i]   = req_tag[i][k];
            core_rsp_ready[i] = (($random(seed) & 3) != 0);
        end
    end

    task automatic apb_access(input addr_t addr, input logic wr, input data_t wdata,
                              output data_t rdata, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        // zero wait states, so the access completes here
        check_bit(1'b1, pready, "pready");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // limits change on the rising edge, away from the core driver
    task automatic release_requests(input int n);
        @(posedge clk);
        for (int i = 0; i < NUM_CORES; i++) begin
            limit[i] = limit[i] + n;
        end
    endtask

    task automatic wait_drained(input logic [NUM_CORES-1:0] mask);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = 1'b1;
            for (int i = 0; i < NUM_CORES; i++) begin
                if (mask[i] && rsp_cnt[i] != limit[i]) begin
                    done = 1'b0;
                end
            end
        end
    endtask

    //////////////////////////////
    // response and request compare

    always @(posedge clk) begin : compare_outputs
        int               k;
        logic [IDX_W-1:0] idx;
        if (rst_n) begin
            for (int i = 0; i < NUM_CORES; i++) begin
                if (core_req_valid[i] && core_req_ready[i]) begin
                    if (!en_expect[i]) begin
                        $display("core %0d had a request taken while disabled at %0t ns",
                                 i, $time);
                        abort_run();
                    end
                    issued[i] = issued[i] + 1;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                idx = mem_req_tag[MEM_TAG_W-1 -: IDX_W];
                k   = mem_cnt[idx];
                if (k >= issued[idx]) begin
                    $display("memory request at %0t ns names core %0d with none pending",
                             $time, idx);
                    abort_run();
                end
                check_addr(req_addr[idx][k], mem_req_addr, "mem_req_addr");
                check_data(req_data[idx][k], mem_req_data, "mem_req_data");
                check_bit(req_write[idx][k], mem_req_write, "mem_req_write");
                check_tag(req_tag[idx][k], mem_req_tag[CORE_TAG_W-1:0], "mem_req_tag");
                // all cores busy, so grants rotate strictly
                if (rr_mode) begin
                    check_index(last_idx + 1'b1, idx, "mem_req_tag core index");
                end
                last_idx     = idx;
                mem_cnt[idx] = mem_cnt[idx] + 1;
                mem_total    = mem_total + 1;
            end
            for (int i = 0; i < NUM_CORES; i++) begin
                if (core_rsp_valid[i] && core_rsp_ready[i]) begin
                    k = rsp_cnt[i];
                    if (k >= mem_cnt[i]) begin
                        $display("core %0d got a response with nothing outstanding at %0t ns",
                                 i, $time);
                        abort_run();
                    end
                    check_tag(req_tag[i][k], core_rsp_tag[i], $sformatf("core_rsp_tag[%0d]", i));
                    check_data(req_write[i][k] ? req_data[i][k] : expected_data(req_addr[i][k]),
                               core_rsp_data[i], $sformatf("core_rsp_data[%0d]", i));
                    rsp_cnt[i] = rsp_cnt[i] + 1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (200 * TOTAL_REQ + 2000) @(posedge clk);
        $display("watchdog expired, the run did not complete in time");
        abort_run();
    end

    //////////////////////////////
    // test sequence

    initial begin : run_tests
        data_t       rd;
        logic        err;
        logic [31:0] r;
        seed           = SEED;
        rst_n          = 1'b0;
        stall_en       = 1'b0;
        core_req_valid = '0;
        core_req_write = '0;
        core_req_addr  = '0;
        core_req_data  = '0;
        core_req_tag   = '0;
        core_rsp_ready = '0;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        en_expect      = '1;
        last_idx       = IDX_W'(NUM_CORES - 1);
        rr_mode        = 1'b1;
        mem_total      = 0;
        // core index in the top address byte keeps addresses per core apart
        for (int i = 0; i < NUM_CORES; i++) begin
            limit[i]   = 0;
            issued[i]  = 0;
            mem_cnt[i] = 0;
            rsp_cnt[i] = 0;
            for (int k = 0; k < MAX_REQ; k++) begin
                r               = $random(seed);
                req_addr[i][k]  = {8'(i), r[23:2], 2'b00};
                req_data[i][k]  = $random(seed);
                req_tag[i][k]   = core_tag_t'(k);
                req_write[i][k] = r[31];
            end
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // reset values
        apb_access(REG_CORE_EN, 1'b0, '0, rd, err);
        check_word(32'hF, rd, "CORE_EN");
        check_bit(1'b0, err, "pslverr");
        check_bit(1'b0, busy, "busy");

        // round robin with memory always ready
        release_requests(N_RR);
        wait_drained('1);
        rr_mode = 1'b0;

        // random back-pressure on both sides
        @(posedge clk);
        stall_en = 1'b1;
        release_requests(N_STALL);
        wait_drained('1);

        // cores 1 and 3 masked off, then released
        apb_access(REG_CORE_EN, 1'b1, 32'h5, rd, err);
        en_expect = 4'b0101;
        apb_access(REG_CORE_EN, 1'b0, '0, rd, err);
        check_word(32'h5, rd, "CORE_EN");
        release_requests(N_MASK);
        wait_drained(4'b0101);
        repeat (20) @(negedge clk);
        apb_access(REG_CORE_EN, 1'b1, 32'hF, rd, err);
        en_expect = '1;
        wait_drained('1);

        // status after drain
        apb_access(REG_REQ_COUNT, 1'b0, '0, rd, err);
        check_word(32'(mem_total), rd, "REQ_COUNT");
        apb_access(REG_OUTSTANDING, 1'b0, '0, rd, err);
        check_word(32'h0, rd, "OUTSTANDING");
        check_bit(1'b0, busy, "busy");
        apb_access(32'hC, 1'b0, '0, rd, err);
        check_bit(1'b1, err, "pslverr");
        check_word(32'h0, rd, "prdata");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/socket_tb_mem.sv ====
// Memory responder for the socket testbench.
// Accepts requests with optional random back-pressure and answers each one
// in order after 0 to 3 cycles. Reads return a pattern of the address.

`timescale 1ns/1ps
`default_nettype none

module socket_tb_mem #(
    parameter int MEM_TAG_W = 6,
    parameter int SEED      = 1
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    stall_en,
    input  wire                    mem_req_valid,
    output logic                   mem_req_ready,
    input  wire                    mem_req_write,
    input  socket_pkg::addr_t      mem_req_addr,
    input  socket_pkg::data_t      mem_req_data,
    input  wire  [MEM_TAG_W-1:0]   mem_req_tag,
    output logic                   mem_rsp_valid,
    input  wire                    mem_rsp_ready,
    output socket_pkg::data_t      mem_rsp_data,
    output logic [MEM_TAG_W-1:0]   mem_rsp_tag
);
    import socket_pkg::*;

    data_t                pend_data [$];
    logic [MEM_TAG_W-1:0] pend_tag  [$];
    int                   pend_due  [$];
    integer               seed;
    int                   cyc;
    logic                 rsp_taken;

    // address rotated left by 8, xor pattern
    function automatic data_t read_pattern(input addr_t a);
        return {a[23:0], a[31:24]} ^ 32'h5A5A5A5A;
    endfunction

    initial begin
        seed          = SEED;
        cyc           = 0;
        rsp_taken     = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_tag   = '0;
    end

    // record accepted requests and retire delivered responses
    always @(posedge clk) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(pend_data.pop_front());
                void'(pend_tag.pop_front());
                void'(pend_due.pop_front());
                rsp_taken = 1'b1;
            end
            if (mem_req_valid && mem_req_ready) begin
                pend_data.push_back(mem_req_write ? mem_req_data : read_pattern(mem_req_addr));
                pend_tag.push_back(mem_req_tag);
                pend_due.push_back(cyc + ($random(seed) & 3));
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            mem_req_ready = 1'b0;
            mem_rsp_valid = 1'b0;
        end else begin
            mem_req_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
            // a response stays up until it is taken
            if (!mem_rsp_valid || rsp_taken) begin
                rsp_taken     = 1'b0;
                mem_rsp_valid = (pend_data.size() != 0) && (pend_due[0] <= cyc);
                if (mem_rsp_valid) begin
                    mem_rsp_data = pend_data[0];
                    mem_rsp_tag  = pend_tag[0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/socket_top.sv ====
// Socket memory concentrator top level.
// Core requests go arbiter -> buffer -> memory; responses come back
// through the router. Config and status sit behind the APB port.

`timescale 1ns/1ps
`default_nettype none

module socket_top #(
    parameter int NUM_CORES  = 4,
    localparam int IDX_W     = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1,
    localparam int MEM_TAG_W = socket_pkg::CORE_TAG_W + IDX_W
) (
    input  wire                                    clk,
    input  wire                                    rst_n,

    // core request ports
    input  wire  [NUM_CORES-1:0]                   core_req_valid,
    output logic [NUM_CORES-1:0]                   core_req_ready,
    input  wire  [NUM_CORES-1:0]                   core_req_write,
    input  socket_pkg::addr_t     [NUM_CORES-1:0]  core_req_addr,
    input  socket_pkg::data_t     [NUM_CORES-1:0]  core_req_data,
    input  socket_pkg::core_tag_t [NUM_CORES-1:0]  core_req_tag,

    // core response ports
    output logic [NUM_CORES-1:0]                   core_rsp_valid,
    input  wire  [NUM_CORES-1:0]                   core_rsp_ready,
    output socket_pkg::data_t     [NUM_CORES-1:0]  core_rsp_data,
    output socket_pkg::core_tag_t [NUM_CORES-1:0]  core_rsp_tag,

    // memory port
    output logic                                   mem_req_valid,
    input  wire                                    mem_req_ready,
    output logic                                   mem_req_write,
    output socket_pkg::addr_t                      mem_req_addr,
    output socket_pkg::data_t                      mem_req_data,
    output logic [MEM_TAG_W-1:0]                   mem_req_tag,
    input  wire                                    mem_rsp_valid,
    output logic                                   mem_rsp_ready,
    input  socket_pkg::data_t                      mem_rsp_data,
    input  wire  [MEM_TAG_W-1:0]                   mem_rsp_tag,

    // apb config port
    input  socket_pkg::addr_t                      paddr,
    input  wire                                    psel,
    input  wire                                    penable,
    input  wire                                    pwrite,
    input  socket_pkg::data_t                      pwdata,
    output socket_pkg::data_t                      prdata,
    output logic                                   pready,
    output logic                                   pslverr,

    output logic                                   busy
);
    import socket_pkg::*;

    logic [NUM_CORES-1:0] core_en;
    logic                 buf_ready;
    logic                 arb_valid;
    logic                 arb_write;
    addr_t                arb_addr;
    data_t                arb_data;
    core_tag_t            arb_tag;
    logic [IDX_W-1:0]     arb_index;
    logic                 req_fire;
    logic                 rsp_fire;

    //////////////////////////////
    // request path
    socket_req_arb #(
        .NUM_CORES      (NUM_CORES)
    ) req_arb_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_req_write (core_req_write),
        .core_req_addr  (core_req_addr),
        .core_req_data  (core_req_data),
        .core_req_tag   (core_req_tag),
        .core_en        (core_en),
        .buf_ready      (buf_ready),
        .arb_valid      (arb_valid),
        .arb_write      (arb_write),
        .arb_addr       (arb_addr),
        .arb_data       (arb_data),
        .arb_tag        (arb_tag),
        .arb_index      (arb_index)
    );

    socket_req_buf #(
        .NUM_CORES      (NUM_CORES)
    ) req_buf_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .arb_valid      (arb_valid),
        .buf_ready      (buf_ready),
        .arb_write      (arb_write),
        .arb_addr       (arb_addr),
        .arb_data       (arb_data),
        .arb_tag        (arb_tag),
        .arb_index      (arb_index),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_write  (mem_req_write),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_tag    (mem_req_tag),
        .req_fire       (req_fire)
    );

    //////////////////////////////
    // response path
    socket_rsp_route #(
        .NUM_CORES      (NUM_CORES)
    ) rsp_route_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_tag    (mem_rsp_tag),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .core_rsp_data  (core_rsp_data),
        .core_rsp_tag   (core_rsp_tag),
        .rsp_fire       (rsp_fire)
    );

    //////////////////////////////
    // config and status
    socket_dcr_regs #(
        .NUM_CORES      (NUM_CORES)
    ) dcr_regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .req_fire       (req_fire),
        .rsp_fire       (rsp_fire),
        .core_en        (core_en),
        .busy           (busy)
    );

endmodule

`default_nettype wire

// ==== logic/socket_rsp_route.sv ====
// Response router on the return path from memory.
// Holds one response, takes the core index from the upper tag bits and
// presents the response to that core only, with its own tag restored.

`timescale 1ns/1ps
`default_nettype none

module socket_rsp_route #(
    parameter int NUM_CORES  = 4,
    localparam int IDX_W     = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1,
    localparam int MEM_TAG_W = socket_pkg::CORE_TAG_W + IDX_W
) (
    input  wire                                    clk,
    input  wire                                    rst_n,

    input  wire                                    mem_rsp_valid,
    output logic                                   mem_rsp_ready,
    input  socket_pkg::data_t                      mem_rsp_data,
    input  wire  [MEM_TAG_W-1:0]                   mem_rsp_tag,

    output logic [NUM_CORES-1:0]                   core_rsp_valid,
    input  wire  [NUM_CORES-1:0]                   core_rsp_ready,
    output socket_pkg::data_t     [NUM_CORES-1:0]  core_rsp_data,
    output socket_pkg::core_tag_t [NUM_CORES-1:0]  core_rsp_tag,
    output logic                                   rsp_fire
);
    import socket_pkg::*;

    logic                 rsp_valid_q;
    data_t                rsp_data_q;
    logic [MEM_TAG_W-1:0] rsp_tag_q;
    logic [IDX_W-1:0]     rsp_idx;

    assign rsp_idx = rsp_tag_q[MEM_TAG_W-1 -: IDX_W];

    // one-hot valid toward the owning core, payload shared by all
    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            core_rsp_valid[i] = rsp_valid_q && (int'(rsp_idx) == i);
            core_rsp_data[i]  = rsp_data_q;
            core_rsp_tag[i]   = rsp_tag_q[CORE_TAG_W-1:0];
        end
    end

    assign rsp_fire      = |(core_rsp_valid & core_rsp_ready);
    assign mem_rsp_ready = !rsp_valid_q || rsp_fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else if (mem_rsp_ready) begin
            rsp_valid_q <= mem_rsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp_valid && mem_rsp_ready) begin
            rsp_data_q <= mem_rsp_data;
            rsp_tag_q  <= mem_rsp_tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/socket_req_buf.sv ====
// Two-entry elastic buffer between the arbiter and the memory request port.
// The core index is prepended to the core tag on entry; one request per
// cycle passes through as long as memory keeps accepting.

`timescale 1ns/1ps
`default_nettype none

module socket_req_buf #(
    parameter int NUM_CORES  = 4,
    localparam int IDX_W     = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1,
    localparam int MEM_TAG_W = socket_pkg::CORE_TAG_W + IDX_W
) (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          arb_valid,
    output logic                         buf_ready,
    input  wire                          arb_write,
    input  socket_pkg::addr_t            arb_addr,
    input  socket_pkg::data_t            arb_data,
    input  socket_pkg::core_tag_t        arb_tag,
    input  wire  [IDX_W-1:0]             arb_index,

    output logic                         mem_req_valid,
    input  wire                          mem_req_ready,
    output logic                         mem_req_write,
    output socket_pkg::addr_t            mem_req_addr,
    output socket_pkg::data_t            mem_req_data,
    output logic [MEM_TAG_W-1:0]         mem_req_tag,
    output logic                         req_fire
);
    import socket_pkg::*;

    logic                 ent_write [2];
    addr_t                ent_addr  [2];
    data_t                ent_data  [2];
    logic [MEM_TAG_W-1:0] ent_tag   [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign buf_ready = (count != 2'd2);
    assign push      = arb_valid && buf_ready;
    assign pop       = mem_req_valid && mem_req_ready;
    assign req_fire  = pop;

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            ent_write[wr_ptr] <= arb_write;
            ent_addr[wr_ptr]  <= arb_addr;
            ent_data[wr_ptr]  <= arb_data;
            ent_tag[wr_ptr]   <= {arb_index, arb_tag};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop)  rd_ptr <= !rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    // head entry drives the memory port
    assign mem_req_valid = (count != 2'd0);
    assign mem_req_write = ent_write[rd_ptr];
    assign mem_req_addr  = ent_addr[rd_ptr];
    assign mem_req_data  = ent_data[rd_ptr];
    assign mem_req_tag   = ent_tag[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/socket_req_arb.sv ====
// Round-robin arbiter over the core request ports.
// Grants one enabled, valid core per cycle while the buffer behind it
// can accept; the request transfers in the same cycle as its grant.

`timescale 1ns/1ps
`default_nettype none

module socket_req_arb #(
    parameter int NUM_CORES = 4,
    localparam int IDX_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
    input  wire                                        clk,
    input  wire                                        rst_n,

    input  wire  [NUM_CORES-1:0]                       core_req_valid,
    output logic [NUM_CORES-1:0]                       core_req_ready,
    input  wire  [NUM_CORES-1:0]                       core_req_write,
    input  socket_pkg::addr_t     [NUM_CORES-1:0]      core_req_addr,
    input  socket_pkg::data_t     [NUM_CORES-1:0]      core_req_data,
    input  socket_pkg::core_tag_t [NUM_CORES-1:0]      core_req_tag,
    input  wire  [NUM_CORES-1:0]                       core_en,

    input  wire                                        buf_ready,
    output logic                                       arb_valid,
    output logic                                       arb_write,
    output socket_pkg::addr_t                          arb_addr,
    output socket_pkg::data_t                          arb_data,
    output socket_pkg::core_tag_t                      arb_tag,
    output logic [IDX_W-1:0]                           arb_index
);
    import socket_pkg::*;

    logic [NUM_CORES-1:0] req_mask;
    logic [IDX_W-1:0]     last_grant;
    logic [IDX_W-1:0]     grant_idx;
    logic                 grant_found;

    // disabled cores never compete
    assign req_mask = core_req_valid & core_en;

    // search starts one past the last granted core
    always_comb begin
        int cand;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int off = 1; off <= NUM_CORES; off++) begin
            cand = (int'(last_grant) + off) % NUM_CORES;
            if (!grant_found && req_mask[cand]) begin
                grant_found = 1'b1;
                grant_idx   = IDX_W'(cand);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            core_req_ready[i] = grant_found && buf_ready && (int'(grant_idx) == i);
        end
    end

    assign arb_valid = grant_found;
    assign arb_write = core_req_write[grant_idx];
    assign arb_addr  = core_req_addr[grant_idx];
    assign arb_data  = core_req_data[grant_idx];
    assign arb_tag   = core_req_tag[grant_idx];
    assign arb_index = grant_idx;

    // pointer moves only when a request is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_grant <= IDX_W'(NUM_CORES - 1);
        end else if (arb_valid && buf_ready) begin
            last_grant <= grant_idx;
        end
    end

endmodule

`default_nettype wire

// ==== logic/socket_dcr_regs.sv ====
// Device configuration registers on an APB slave port.
// Holds the per-core enable mask, a count of memory requests sent and the
// number of requests still waiting for a response; busy follows the latter.

`timescale 1ns/1ps
`default_nettype none

module socket_dcr_regs #(
    parameter int NUM_CORES = 4
) (
    input  wire                    clk,
    input  wire                    rst_n,

    input  socket_pkg::addr_t      paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  socket_pkg::data_t      pwdata,
    output socket_pkg::data_t      prdata,
    output logic                   pready,
    output logic                   pslverr,

    input  wire                    req_fire,
    input  wire                    rsp_fire,
    output logic [NUM_CORES-1:0]   core_en,
    output logic                   busy
);
    import socket_pkg::*;

    apb_state_t apb_state;
    logic       access_cyc;
    logic       addr_hit;
    logic       wr_en;
    data_t      req_count;
    data_t      outstanding;

    //////////////////////////////
    // apb phase tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            apb_state <= idle;
        end else begin
            case (apb_state)
                setup:   apb_state <= (psel && penable) ? access : idle;
                default: apb_state <= (psel && !penable) ? setup : idle;
            endcase
        end
    end

    assign access_cyc = psel && penable && (apb_state == setup);
    assign addr_hit   = (paddr == REG_CORE_EN) || (paddr == REG_REQ_COUNT)
                     || (paddr == REG_OUTSTANDING);
    assign wr_en      = access_cyc && pwrite;

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access_cyc && !addr_hit;

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CORE_EN:     prdata = data_t'(core_en);
            REG_REQ_COUNT:   prdata = req_count;
            REG_OUTSTANDING: prdata = outstanding;
            default:         prdata = '0;
        endcase
    end

    //////////////////////////////
    // registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_en     <= '1;
            req_count   <= '0;
            outstanding <= '0;
        end else begin
            if (wr_en && paddr == REG_CORE_EN) begin
                core_en <= pwdata[NUM_CORES-1:0];
            end
            // a clear in the same cycle as a transfer keeps that transfer
            if (wr_en && paddr == REG_REQ_COUNT) begin
                req_count <= data_t'(req_fire);
            end else if (req_fire) begin
                req_count <= req_count + 1'b1;
            end
            case ({req_fire, rsp_fire})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign busy = (outstanding != '0);

endmodule

`default_nettype wire

// ==== logic/socket_pkg.sv ====
// Shared widths, payload types and register map of the socket memory concentrator.
// Modules pull these in with a wildcard import and use scoped names in port lists.

`default_nettype none

package socket_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int CORE_TAG_W = 4;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [CORE_TAG_W-1:0] core_tag_t;

    //////////////////////////////
    // config register byte offsets
    localparam addr_t REG_CORE_EN     = 32'h0;
    localparam addr_t REG_REQ_COUNT   = 32'h4;
    localparam addr_t REG_OUTSTANDING = 32'h8;

    // apb phase seen by the register block
    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apb_state_t;

endpackage

`default_nettype wire
